// ==== all.f ====
design/board_pkg.sv
design/drive_activity_if.sv
design/board_sync.sv
design/audio_channel_mixer.sv
design/drive_indicators.sv
design/board_glue_top.sv
bench/board_glue_checker.sv
bench/board_glue_tb.sv

// ==== bench/board_glue_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Inputs change on the rising edge, outputs are compared on the falling
// edge; the first mismatch ends the run
//////////////////////////////////////////////////////////////////////
`default_nettype none

module board_glue_tb;
  import board_pkg::*;

  localparam int clk_period = 8;
  localparam int n_pass     = 200;              // Pass-through samples
  localparam int n_mix      = 150;              // Samples per switch setting
  localparam int n_track    = 200;              // Random track values
  localparam int n_rep      = 5;                // Repeated strobes
  localparam int rep_gap    = 40;               // Cycles between them
  localparam int hold_cyc   = act_hold_ticks * clk7_div;
  localparam int total_cyc  = 4 + n_pass + 4 * (n_mix + 8) + n_track
                              + act_n * (hold_cyc + 4) + n_rep * rep_gap + hold_cyc + 8;
  localparam int wd_margin  = 100;

  logic                  clk_28;
  logic                  pll_locked;
  logic                  sw_exchan;
  logic                  sw_mix;
  logic [sample_w-1:0]   ldata;
  logic [sample_w-1:0]   rdata;
  track_t                track;
  logic [act_n-1:0]      strb;                  // {floppy_fwr, floppy_frd, hd_fwr, hd_frd}
  logic [sample_w-1:0]   aud_left;
  logic [sample_w-1:0]   aud_right;
  seg_t                  hex0;
  seg_t                  hex1;
  logic [act_n-1:0]      led_act;
  logic [31:0]           rng;                   // xorshift state

  // Inputs as seen by the DUT, kept for the reference model
  logic [2:0]            exch_h = '0;           // Index 2 is three cycles back
  logic [2:0]            mix_h  = '0;
  logic [sample_w-1:0]   l_prev = '0;
  logic [sample_w-1:0]   r_prev = '0;
  track_t                track_prev = '0;
  logic                  cmp_en = 1'b0;

  board_glue_top board_glue_top_i (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .sw_exchan  (sw_exchan),
    .sw_mix     (sw_mix),
    .ldata      (ldata),
    .rdata      (rdata),
    .track      (track),
    .floppy_fwr (strb[3]),
    .floppy_frd (strb[2]),
    .hd_fwr     (strb[1]),
    .hd_frd     (strb[0]),
    .aud_left   (aud_left),
    .aud_right  (aud_right),
    .hex0       (hex0),
    .hex1       (hex1),
    .led_act    (led_act)
  );

  bind drive_indicators board_glue_checker board_glue_checker_i (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .strb       (act_strb),
    .hex0       (hex0),
    .hex1       (hex1),
    .led_act    (led_act)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Exchange, then 3/4 own plus 1/4 other; returns {left, right}
  function automatic logic [2*sample_w-1:0] ref_mix(input logic exch, input logic mix,
                                                    input sample_t l, input sample_t r);
    int own_l;
    int own_r;
    int out_l;
    int out_r;
    own_l = exch ? int'(r) : int'(l);
    own_r = exch ? int'(l) : int'(r);
    out_l = mix ? own_l - (own_l >>> 2) + (own_r >>> 2) : own_l;
    out_r = mix ? own_r - (own_r >>> 2) + (own_l >>> 2) : own_r;
    return {out_l[sample_w-1:0], out_r[sample_w-1:0]};
  endfunction

  // Returns {hex1, hex0}
  function automatic logic [2*seg_w-1:0] ref_digits(input track_t t);
    return {seg_font[t[7:4]], seg_font[t[3:0]]};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      $display("TEST FAILED");
      $fatal(1, "Output mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Clock, compare and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    clk_28 = 1'b0;
    forever #(clk_period / 2) clk_28 = ~clk_28;
  end

  always @(negedge clk_28) begin : compare_outputs
    logic [2*sample_w-1:0] exp_mix;
    logic [2*seg_w-1:0]    exp_seg;
    exp_mix = ref_mix(exch_h[2], mix_h[2], l_prev, r_prev); // Switches lag by sync
    exp_seg = ref_digits(track_prev);
    if (cmp_en) begin
      check_value("aud_left", aud_left, exp_mix[2*sample_w-1:sample_w]);
      check_value("aud_right", aud_right, exp_mix[sample_w-1:0]);
      check_value("hex0", hex0, exp_seg[seg_w-1:0]);
      check_value("hex1", hex1, exp_seg[2*seg_w-1:seg_w]);
    end
    exch_h     = {exch_h[1:0], sw_exchan};
    mix_h      = {mix_h[1:0], sw_mix};
    l_prev     = ldata;
    r_prev     = rdata;
    track_prev = track;
  end

  initial begin : watchdog
    #(clk_period * (total_cyc + wd_margin));
    $display("Watchdog expired before all tests finished");
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////
  task automatic apply_pair(input logic [sample_w-1:0] l, input logic [sample_w-1:0] r);
    @(posedge clk_28);
    ldata <= l;
    rdata <= r;
  endtask

  task automatic apply_samples(input int n);
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      apply_pair(rng[sample_w-1:0], rng[sample_w+15:16]);
    end
  endtask

  task automatic apply_tracks(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_28);
      rng = xorshift32(rng);
      track <= rng[track_w-1:0];
    end
  endtask

  // One strobe, then watch the LED through its whole hold window
  task automatic pulse_single(input int idx);
    @(posedge clk_28);
    strb <= 4'b1 << idx;
    @(posedge clk_28);
    strb <= '0;
    @(negedge clk_28);                          // One cycle after the strobe
    check_value("led_act", led_act, 4'b1 << idx);
    for (int t = 2; t <= hold_cyc + 2; t++) begin
      @(negedge clk_28);
      if (t <= hold_cyc - 3) begin
        check_value("led_act", led_act, 4'b1 << idx);
      end
    end
    check_value("led_act", led_act, '0);        // Off at the latest bound
  endtask

  // Strobes closer than the hold time keep the LED lit
  task automatic pulse_repeat(input int idx);
    for (int c = 0; c < n_rep * rep_gap; c++) begin
      @(posedge clk_28);
      strb <= (c % rep_gap == 0) ? (4'b1 << idx) : '0;
      @(negedge clk_28);
      if (c > 0) begin
        check_value("led_act", led_act, 4'b1 << idx);
      end
    end
    @(posedge clk_28);
    strb <= '0;
    repeat (hold_cyc + 2) @(negedge clk_28);
    check_value("led_act", led_act, '0);
  endtask

  initial begin : stimulus
    int chk_fails;
    pll_locked = 1'b0;                          // In reset from time zero
    sw_exchan  = 1'b0;
    sw_mix     = 1'b0;
    ldata      = '0;
    rdata      = '0;
    track      = '0;
    strb       = '0;
    rng        = 32'd24;                        // Seed
    repeat (3) @(posedge clk_28);
    pll_locked <= 1'b1;
    @(negedge clk_28);
    check_value("aud_left", aud_left, '0);
    check_value("aud_right", aud_right, '0);
    check_value("hex0", hex0, seg_blank);
    check_value("hex1", hex1, seg_blank);
    check_value("led_act", led_act, '0);
    cmp_en <= 1'b1;                             // Compare from next falling edge

    apply_samples(n_pass);                      // Switches low, straight through
    for (int s = 0; s < 4; s++) begin
      @(posedge clk_28);
      sw_exchan <= s[0];
      sw_mix    <= s[1];
      repeat (3) @(posedge clk_28);             // Let the synchronizers settle
      apply_pair(15'h3fff, 15'h4000);           // Full-scale corners
      apply_pair(15'h4000, 15'h3fff);
      apply_pair(15'h4000, 15'h4000);
      apply_pair(15'h7fff, 15'h0001);
      apply_samples(n_mix);
    end

    apply_tracks(n_track);

    for (int i = 0; i < act_n; i++) begin
      pulse_single(i);
    end
    pulse_repeat(act_n - 1);                    // Floppy write LED

    repeat (2) @(negedge clk_28);
    chk_fails = board_glue_top_i.drive_indicators_i.board_glue_checker_i.fail_cnt;
    if (chk_fails == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", chk_fails);
      $display("TEST FAILED");
      $fatal(1, "Assertion failures");
    end
  end

endmodule

`default_nettype wire

// ==== bench/board_glue_checker.sv ====
//////////////////////////////////////////////////////////////////////
// Bound into drive_indicators; strb is its internal strobe vector
// fail_cnt counts assertion failures for the testbench summary
//////////////////////////////////////////////////////////////////////
`default_nettype none

module board_glue_checker (
  input wire                          clk_28,      // 28 MHz system clock
  input wire                          pll_locked,  // Async reset, active low
  input wire [board_pkg::act_n-1:0]   strb,        // Strobes, LED order
  input wire board_pkg::seg_t         hex0,        // Low digit
  input wire board_pkg::seg_t         hex1,        // High digit
  input wire [board_pkg::act_n-1:0]   led_act      // Activity LEDs
);
  import board_pkg::*;

  int fail_cnt = 0;                             // Read by the testbench

  // Reset values seen one edge after reset was sampled low
  reset_values: assert property (@(posedge clk_28)
    !pll_locked |=> (hex0 == seg_blank && hex1 == seg_blank && led_act == '0))
    else begin
      fail_cnt++;
      $error("Outputs left their reset values while reset was low");
    end

  // Every strobe lights its own LED on the next edge
  for (genvar i = 0; i < act_n; i++) begin : g_led_on
    led_on: assert property (@(posedge clk_28) disable iff (!pll_locked)
      strb[i] |=> led_act[i])
      else begin
        fail_cnt++;
        $error("LED %0d not lit after its strobe", i);
      end
  end

  // Display always driven once out of reset
  hex_known: assert property (@(posedge clk_28) disable iff (!pll_locked)
    !$isunknown({hex1, hex0}))
    else begin
      fail_cnt++;
      $error("Track display carries X");
    end

endmodule

`default_nettype wire

// ==== design/board_glue_top.sv ====
//////////////////////////////////////////////////////////////////////
// 28 MHz board glue; all inputs are levels or one-cycle strobes
//////////////////////////////////////////////////////////////////////
`default_nettype none

module board_glue_top (
  input  wire                          clk_28,      // 28 MHz from PLL
  input  wire                          pll_locked,  // Async reset, active low
  input  wire                          sw_exchan,   // L/R exchange switch
  input  wire                          sw_mix,      // Centred mix switch
  input  board_pkg::sample_t           ldata,       // Left DAC sample
  input  board_pkg::sample_t           rdata,       // Right DAC sample
  input  board_pkg::track_t            track,       // Floppy track
  input  wire                          floppy_fwr,  // Floppy FIFO write
  input  wire                          floppy_frd,  // Floppy FIFO read
  input  wire                          hd_fwr,      // HD FIFO write
  input  wire                          hd_frd,      // HD FIFO read
  output board_pkg::sample_t           aud_left,    // To codec, left
  output board_pkg::sample_t           aud_right,   // To codec, right
  output board_pkg::seg_t              hex0,        // Track low digit
  output board_pkg::seg_t              hex1,        // Track high digit
  output logic [board_pkg::act_n-1:0]  led_act      // Drive activity LEDs
);

  logic exchan_s;                               // Synced switches
  logic mix_s;
  logic tick_7;                                 // 7 MHz enable

  drive_activity_if act_if ();

  // Source side of the activity bundle
  assign act_if.track      = track;
  assign act_if.floppy_fwr = floppy_fwr;
  assign act_if.floppy_frd = floppy_frd;
  assign act_if.hd_fwr     = hd_fwr;
  assign act_if.hd_frd     = hd_frd;

  //////////////////////////////////////////////////////////////////////
  // Modules
  //////////////////////////////////////////////////////////////////////
  board_sync board_sync_i (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .sw_exchan  (sw_exchan),
    .sw_mix     (sw_mix),
    .exchan_s   (exchan_s),
    .mix_s      (mix_s),
    .tick_7     (tick_7)
  );

  audio_channel_mixer audio_channel_mixer_i (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .exchan_s   (exchan_s),
    .mix_s      (mix_s),
    .ldata      (ldata),
    .rdata      (rdata),
    .aud_left   (aud_left),
    .aud_right  (aud_right)
  );

  drive_indicators drive_indicators_i (
    .clk_28     (clk_28),
    .pll_locked (pll_locked),
    .tick_7     (tick_7),
    .act        (act_if.sink),
    .hex0       (hex0),
    .hex1       (hex1),
    .led_act    (led_act)
  );

endmodule

`default_nettype wire

// ==== design/drive_indicators.sv ====
//////////////////////////////////////////////////////////////////////
// LED hold counts 7 MHz ticks, so off time jitters by up to 4 cycles
// led_act is {floppy_fwr, floppy_frd, hd_fwr, hd_frd}, MSB first
//////////////////////////////////////////////////////////////////////
`default_nettype none

module drive_indicators (
  input  wire                              clk_28,     // 28 MHz system clock
  input  wire                              pll_locked, // Async reset, active low
  input  wire                              tick_7,     // 7 MHz enable
  drive_activity_if.sink                   act,        // Track and FIFO strobes
  output board_pkg::seg_t                  hex0,       // Low track nibble
  output board_pkg::seg_t                  hex1,       // High track nibble
  output logic [board_pkg::act_n-1:0]      led_act     // Stretched activity
);
  import board_pkg::*;

  logic [act_n-1:0]                act_strb;    // Strobes, LED order
  logic [act_n-1:0][act_cnt_w-1:0] hold_cnt;    // Ticks left per LED

  //////////////////////////////////////////////////////////////////////
  // Track display
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      hex0 <= seg_blank;                        // Dark until first track
      hex1 <= seg_blank;
    end else begin
      hex0 <= seg_font[act.track[3:0]];         // Units digit
      hex1 <= seg_font[act.track[7:4]];         // Sixteens digit
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Activity stretch
  //////////////////////////////////////////////////////////////////////
  assign act_strb = {act.floppy_fwr, act.floppy_frd, act.hd_fwr, act.hd_frd};

  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      hold_cnt <= '0;
    end else begin
      for (int i = 0; i < act_n; i++) begin
        if (act_strb[i]) begin
          hold_cnt[i] <= act_cnt_w'(act_hold_ticks); // Strobe beats tick
        end else if (tick_7 && (hold_cnt[i] != '0)) begin
          hold_cnt[i] <= hold_cnt[i] - 1'b1;  // Count down to idle
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < act_n; i++) begin
      led_act[i] = (hold_cnt[i] != '0);         // Lit while holding
    end
  end

endmodule

`default_nettype wire

// ==== design/audio_channel_mixer.sv ====
//////////////////////////////////////////////////////////////////////
// Swap then mix; 3/4 own + 1/4 other stays in range, no saturation
//////////////////////////////////////////////////////////////////////
`default_nettype none

module audio_channel_mixer (
  input  wire                clk_28,            // 28 MHz system clock
  input  wire                pll_locked,        // Async reset, active low
  input  wire                exchan_s,          // Swap left and right
  input  wire                mix_s,             // Centred mix
  input  board_pkg::sample_t ldata,             // Left DAC sample
  input  board_pkg::sample_t rdata,             // Right DAC sample
  output board_pkg::sample_t aud_left,          // Registered left
  output board_pkg::sample_t aud_right          // Registered right
);
  import board_pkg::*;

  sample_t xch_l;                               // After exchange
  sample_t xch_r;
  sample_t mix_l;                               // After mix
  sample_t mix_r;

  //////////////////////////////////////////////////////////////////////
  // Exchange
  //////////////////////////////////////////////////////////////////////
  assign xch_l = exchan_s ? rdata : ldata;
  assign xch_r = exchan_s ? ldata : rdata;

  //////////////////////////////////////////////////////////////////////
  // Centred mix
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    if (mix_s) begin
      mix_l = xch_l - (xch_l >>> 2) + (xch_r >>> 2); // Arithmetic shifts
      mix_r = xch_r - (xch_r >>> 2) + (xch_l >>> 2);
    end else begin
      mix_l = xch_l;                            // Straight through
      mix_r = xch_r;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      aud_left  <= '0;                          // Silence out of reset
      aud_right <= '0;
    end else begin
      aud_left  <= mix_l;
      aud_right <= mix_r;
    end
  end

endmodule

`default_nettype wire

// ==== design/board_sync.sv ====
//////////////////////////////////////////////////////////////////////
// Switches are async to clk_28; tick_7 is an enable, not a clock
//////////////////////////////////////////////////////////////////////
`default_nettype none

module board_sync (
  input  wire  clk_28,                          // 28 MHz system clock
  input  wire  pll_locked,                      // Async reset, active low
  input  wire  sw_exchan,                       // Raw L/R exchange switch
  input  wire  sw_mix,                          // Raw centred mix switch
  output logic exchan_s,                        // Synced exchange
  output logic mix_s,                           // Synced mix
  output logic tick_7                           // One cycle in clk7_div
);
  import board_pkg::*;

  logic [sync_stages-1:0][1:0] sync_q;          // Stage 0 samples the pins
  logic [clk7_cnt_w-1:0]       clk7_cnt;        // 7 MHz phase

  //////////////////////////////////////////////////////////////////////
  // Switch synchronizers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= {sw_mix, sw_exchan};         // Metastable stage
      for (int i = 1; i < sync_stages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign exchan_s = sync_q[sync_stages-1][0];
  assign mix_s    = sync_q[sync_stages-1][1];

  //////////////////////////////////////////////////////////////////////
  // 7 MHz divider
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_28 or negedge pll_locked) begin
    if (!pll_locked) begin
      clk7_cnt <= clk7_cnt_w'(clk7_cnt_rst);    // First tick 2 cycles out
    end else if (tick_7) begin
      clk7_cnt <= '0;                           // Wrap at top
    end else begin
      clk7_cnt <= clk7_cnt + 1'b1;
    end
  end

  assign tick_7 = (clk7_cnt == clk7_cnt_w'(clk7_div - 1)); // Top value

endmodule

`default_nettype wire

// ==== design/drive_activity_if.sv ====
//////////////////////////////////////////////////////////////////////
// Track number and FIFO strobes from the core; levels only, no ack
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface drive_activity_if;
  import board_pkg::*;

  track_t track;                                // Current floppy track
  logic   floppy_fwr;                           // Floppy FIFO write
  logic   floppy_frd;                           // Floppy FIFO read
  logic   hd_fwr;                               // HD FIFO write
  logic   hd_frd;                               // HD FIFO read

  modport source (
    output track, floppy_fwr, floppy_frd, hd_fwr, hd_frd
  );

  modport sink (
    input  track, floppy_fwr, floppy_frd, hd_fwr, hd_frd
  );

endinterface

`default_nettype wire

// ==== design/board_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Widths, timing constants and seven-segment font for the board glue
// Segments are active low; bit 0 is segment a
//////////////////////////////////////////////////////////////////////
`default_nettype none

package board_pkg;

  //////////////////////////////////////////////////////////////////////
  // Data widths and types
  //////////////////////////////////////////////////////////////////////
  localparam int sample_w = 15;                 // DAC sample width
  localparam int track_w  = 8;                  // Floppy track number
  localparam int seg_w    = 7;                  // Segments per digit
  localparam int act_n    = 4;                  // Activity LEDs

  typedef logic signed [sample_w-1:0] sample_t; // Signed DAC sample
  typedef logic [track_w-1:0]         track_t;  // Track number
  typedef logic [seg_w-1:0]           seg_t;    // One digit, active low

  //////////////////////////////////////////////////////////////////////
  // Timing
  //////////////////////////////////////////////////////////////////////
  localparam int sync_stages    = 2;            // Switch synchronizer depth
  localparam int clk7_div       = 4;            // clk_28 cycles per 7 MHz tick
  localparam int clk7_cnt_w     = $clog2(clk7_div);
  localparam int clk7_cnt_rst   = 2;            // Divider start value, as on the board
  localparam int act_hold_ticks = 16;           // LED hold after last strobe
  localparam int act_cnt_w      = 5;            // Must hold act_hold_ticks

  //////////////////////////////////////////////////////////////////////
  // Hex font, gfedcba, low = segment on
  //////////////////////////////////////////////////////////////////////
  localparam seg_t seg_blank = '1;              // All segments off

  localparam seg_t seg_font [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,                 // 0 1 2 3
    7'h19, 7'h12, 7'h02, 7'h78,                 // 4 5 6 7
    7'h00, 7'h10, 7'h08, 7'h03,                 // 8 9 A b
    7'h46, 7'h21, 7'h06, 7'h0e                  // C d E F
  };

endpackage

`default_nettype wire
